//--- tlul_pkg.sv
/*
  TL-UL bus definitions for the register slave and its testbench.
  Import with tlul_pkg::* in any module that touches the A or D channel.
*/

package tlul_pkg;

  ////////////////////////////////////////////////////////////
  // Field widths
  ////////////////////////////////////////////////////////////

  // Byte address width of the A channel
  localparam int TL_AW = 32;

  // Data bus width
  localparam int TL_DW = 32;

  // One mask bit per byte lane
  localparam int TL_DBW = TL_DW / 8;

  // Log2 of the transfer size in bytes
  localparam int TL_SZW = 2;

  // Source identifier, echoed on the D channel
  localparam int TL_AIW = 8;

  ////////////////////////////////////////////////////////////
  // Opcodes
  ////////////////////////////////////////////////////////////

  // A channel requests, UL subset only
  typedef enum logic [2:0] {
    PutFullData    = 3'h0,
    PutPartialData = 3'h1,
    Get            = 3'h4
  } tl_a_op_e;

  // D channel responses
  // AccessAckData answers Get, AccessAck answers both puts
  typedef enum logic [2:0] {
    AccessAck     = 3'h0,
    AccessAckData = 3'h1
  } tl_d_op_e;

  // Size codes that the slave supports
  // 0 is one byte, 1 is a half word, 2 is a full word
  // Anything above 2 exceeds the bus width

endpackage

//--- regs_pkg.sv
/*
  Register map of the bank behind the TL-UL adapter.
  Offsets, widths and reset values used by the RTL and by the testbench model.
*/

package regs_pkg;

  // Register interface widths
  localparam int REG_AW = 8;
  localparam int REG_DW = 32;
  localparam int REG_BW = REG_DW / 8;

  ////////////////////////////////////////////////////////////
  // Address map
  ////////////////////////////////////////////////////////////

  // Word offsets within the block
  typedef enum logic [7:0] {
    REG_CTRL    = 8'h00,
    REG_SCRATCH = 8'h04,
    REG_ID      = 8'h08,
    REG_WCOUNT  = 8'h0C
  } reg_addr_e;

  // Implemented width of the narrow registers
  localparam int CTRL_W   = 8;
  localparam int WCOUNT_W = 16;

  ////////////////////////////////////////////////////////////
  // Reset values and constants
  ////////////////////////////////////////////////////////////

  localparam logic [CTRL_W-1:0] CTRL_RESET    = '0;
  localparam logic [REG_DW-1:0] SCRATCH_RESET = '0;

  // Read-only identification word
  localparam logic [REG_DW-1:0] BLOCK_ID = 32'h7e61_0001;

endpackage

//--- tlul_err.sv
/*
  Combinational protocol checker for A-channel requests.
  Flags illegal opcode, size, alignment and mask; valid only with tl_a_valid_i.
*/

`timescale 1ns/10ps

module tlul_err
  import tlul_pkg::*;
(
  input  logic              tl_a_valid_i,
  input  tl_a_op_e          tl_a_opcode_i,
  input  logic [TL_SZW-1:0] tl_a_size_i,
  input  logic [TL_DBW-1:0] tl_a_mask_i,
  input  logic [TL_AW-1:0]  tl_a_address_i,
  output logic              tl_err_o
);

  // Lanes the request may touch
  logic [TL_DBW-1:0] lane_mask;

  // Individual rule violations
  logic op_err;
  logic size_err;
  logic addr_err;
  logic mask_err;
  logic full_err;

  ////////////////////////////////////////////////////////////
  // Lane selection from size and low address bits
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (tl_a_size_i)
      // Single byte at the addressed lane
      2'd0: lane_mask = TL_DBW'(4'b0001) << tl_a_address_i[1:0];
      // Half word, lower or upper pair
      2'd1: lane_mask = TL_DBW'(4'b0011) << {tl_a_address_i[1], 1'b0};
      // Full word
      2'd2: lane_mask = '1;
      // Oversized, no lane is legal
      default: lane_mask = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Rule checks
  ////////////////////////////////////////////////////////////

  // Only the three UL request opcodes
  assign op_err = !(tl_a_opcode_i inside {PutFullData, PutPartialData, Get});

  // Transfer wider than the bus
  assign size_err = (tl_a_size_i > 2'd2);

  // Address must be a multiple of the size
  always_comb begin
    case (tl_a_size_i)
      2'd0:    addr_err = 1'b0;
      2'd1:    addr_err = tl_a_address_i[0];
      2'd2:    addr_err = |tl_a_address_i[1:0];
      default: addr_err = 1'b0;
    endcase
  end

  // Mask bit outside the selected lanes
  assign mask_err = |(tl_a_mask_i & ~lane_mask);

  // PutFullData has to fill every selected lane
  assign full_err = (tl_a_opcode_i == PutFullData) &&
                    ((tl_a_mask_i & lane_mask) != lane_mask);

  // Meaningful only while a request is presented
  assign tl_err_o = tl_a_valid_i &
                    (op_err | size_err | addr_err | mask_err | full_err);

endmodule

//--- tlul_adapter_reg.sv
/*
  Bridges single-beat TL-UL requests onto a strobe-based register interface.
  One request in flight; the D response is held until the host takes it.
*/

`timescale 1ns/10ps

module tlul_adapter_reg
  import tlul_pkg::*;
  import regs_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,

  // A channel
  input  logic              tl_a_valid_i,
  input  tl_a_op_e          tl_a_opcode_i,
  input  logic [TL_SZW-1:0] tl_a_size_i,
  input  logic [TL_DBW-1:0] tl_a_mask_i,
  input  logic [TL_AW-1:0]  tl_a_address_i,
  input  logic [TL_AIW-1:0] tl_a_source_i,
  input  logic [TL_DW-1:0]  tl_a_data_i,
  output logic              tl_a_ready_o,

  // D channel
  output logic              tl_d_valid_o,
  output tl_d_op_e          tl_d_opcode_o,
  output logic [TL_SZW-1:0] tl_d_size_o,
  output logic [TL_AIW-1:0] tl_d_source_o,
  output logic [TL_DW-1:0]  tl_d_data_o,
  output logic              tl_d_error_o,
  input  logic              tl_d_ready_i,

  // Protocol checker result
  input  logic              tl_err_i,

  // Register side
  output logic              re_o,
  output logic              we_o,
  output logic [REG_AW-1:0] addr_o,
  output logic [REG_DW-1:0] wdata_o,
  output logic [REG_BW-1:0] be_o,
  input  logic [REG_DW-1:0] rdata_i,
  input  logic              error_i
);

  // Response pending on D
  logic outstanding_q;

  // Handshakes
  logic a_ack;
  logic d_ack;

  // Decoded request type, qualified by acceptance
  logic rd_req;
  logic wr_req;

  // Errors found before the register bank sees the request
  logic addr_align_err;
  logic err_internal;

  // Captured response fields
  logic [TL_AIW-1:0] reqid_q;
  logic [TL_SZW-1:0] reqsz_q;
  tl_d_op_e          rspop_q;
  logic [TL_DW-1:0]  rdata_q;
  logic              error_q;

  assign a_ack = tl_a_valid_i & tl_a_ready_o;
  assign d_ack = tl_d_valid_o & tl_d_ready_i;

  assign wr_req = a_ack & ((tl_a_opcode_i == PutFullData) |
                           (tl_a_opcode_i == PutPartialData));
  assign rd_req = a_ack & (tl_a_opcode_i == Get);

  ////////////////////////////////////////////////////////////
  // Error handling
  ////////////////////////////////////////////////////////////

  // Register writes are whole-word addressed
  assign addr_align_err = wr_req & (|tl_a_address_i[1:0]);

  assign err_internal = addr_align_err | tl_err_i;

  ////////////////////////////////////////////////////////////
  // Register strobes
  ////////////////////////////////////////////////////////////

  // High only in the acceptance cycle, suppressed on any early error
  assign we_o = wr_req & ~err_internal;
  assign re_o = rd_req & ~err_internal;

  // Word address into the bank
  assign addr_o  = {tl_a_address_i[REG_AW-1:2], 2'b00};
  assign wdata_o = tl_a_data_i;
  assign be_o    = tl_a_mask_i;

  ////////////////////////////////////////////////////////////
  // Outstanding tracking and response capture
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      outstanding_q <= 1'b0;
    end else if (a_ack) begin
      outstanding_q <= 1'b1;
    end else if (d_ack) begin
      outstanding_q <= 1'b0;
    end
  end

  // Held stable until the D handshake since no new request is accepted
  always_ff @(posedge clk_i) begin
    if (a_ack) begin
      reqid_q <= tl_a_source_i;
      reqsz_q <= tl_a_size_i;
      // Data response for every Get, errored or not
      rspop_q <= rd_req ? AccessAckData : AccessAck;
      rdata_q <= err_internal ? '1 : rdata_i;
      error_q <= error_i | err_internal;
    end
  end

  // Accept only with nothing pending
  assign tl_a_ready_o = ~outstanding_q;

  assign tl_d_valid_o  = outstanding_q;
  assign tl_d_opcode_o = rspop_q;
  assign tl_d_size_o   = reqsz_q;
  assign tl_d_source_o = reqid_q;
  assign tl_d_data_o   = rdata_q;
  assign tl_d_error_o  = error_q;

endmodule

//--- reg_block.sv
/*
  Four-register bank driven by single-cycle read and write strobes.
  Read data and error return combinationally; writes land on the strobe edge.
*/

`timescale 1ns/10ps

module reg_block
  import regs_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,

  // Strobe interface
  input  logic              re_i,
  input  logic              we_i,
  input  logic [REG_AW-1:0] addr_i,
  input  logic [REG_DW-1:0] wdata_i,
  input  logic [REG_BW-1:0] be_i,
  output logic [REG_DW-1:0] rdata_o,
  output logic              error_o
);

  // Register storage
  logic [CTRL_W-1:0]   ctrl_q;
  logic [REG_DW-1:0]   scratch_q;
  logic [WCOUNT_W-1:0] wcount_q;

  // Address decode
  logic hit_ctrl;
  logic hit_scratch;
  logic hit_id;
  logic hit_wcount;
  logic addr_miss;

  // Access qualifiers
  logic wr_ro;
  logic wr_ok;

  ////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////

  always_comb begin
    hit_ctrl    = 1'b0;
    hit_scratch = 1'b0;
    hit_id      = 1'b0;
    hit_wcount  = 1'b0;
    addr_miss   = 1'b0;
    case (addr_i)
      REG_CTRL:    hit_ctrl    = 1'b1;
      REG_SCRATCH: hit_scratch = 1'b1;
      REG_ID:      hit_id      = 1'b1;
      REG_WCOUNT:  hit_wcount  = 1'b1;
      default:     addr_miss   = 1'b1;
    endcase
  end

  // Writes to the read-only words
  assign wr_ro = we_i & (hit_id | hit_wcount);

  // Only reported while a strobe is active
  assign error_o = (re_i | we_i) & (addr_miss | wr_ro);

  // Write that actually updates state
  assign wr_ok = we_i & ~error_o;

  ////////////////////////////////////////////////////////////
  // Read mux
  ////////////////////////////////////////////////////////////

  always_comb begin
    rdata_o = '0;
    // Errored or idle reads return zero
    if (re_i && !error_o) begin
      case (1'b1)
        hit_ctrl:    rdata_o = {{(REG_DW-CTRL_W){1'b0}}, ctrl_q};
        hit_scratch: rdata_o = scratch_q;
        hit_id:      rdata_o = BLOCK_ID;
        hit_wcount:  rdata_o = {{(REG_DW-WCOUNT_W){1'b0}}, wcount_q};
        default:     rdata_o = '0;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Writable registers
  ////////////////////////////////////////////////////////////

  // Control holds a single byte, lane 0 only
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctrl_q <= CTRL_RESET;
    end else if (wr_ok && hit_ctrl && be_i[0]) begin
      ctrl_q <= wdata_i[CTRL_W-1:0];
    end
  end

  // Scratch merges each enabled byte lane
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scratch_q <= SCRATCH_RESET;
    end else if (wr_ok && hit_scratch) begin
      for (int b = 0; b < REG_BW; b++) begin
        if (be_i[b]) begin
          scratch_q[b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Write counter
  ////////////////////////////////////////////////////////////

  // Counts every accepted write, wraps at the top
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wcount_q <= '0;
    end else if (wr_ok) begin
      wcount_q <= wcount_q + WCOUNT_W'(1);
    end
  end

endmodule

//--- tlul_reg_top.sv
/*
  TL-UL register slave top; ties the checker, adapter and register bank.
*/

`timescale 1ns/10ps

module tlul_reg_top
  import tlul_pkg::*;
  import regs_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,

  // A channel
  input  logic              tl_a_valid_i,
  input  tl_a_op_e          tl_a_opcode_i,
  input  logic [TL_SZW-1:0] tl_a_size_i,
  input  logic [TL_DBW-1:0] tl_a_mask_i,
  input  logic [TL_AW-1:0]  tl_a_address_i,
  input  logic [TL_AIW-1:0] tl_a_source_i,
  input  logic [TL_DW-1:0]  tl_a_data_i,
  output logic              tl_a_ready_o,

  // D channel
  output logic              tl_d_valid_o,
  output tl_d_op_e          tl_d_opcode_o,
  output logic [TL_SZW-1:0] tl_d_size_o,
  output logic [TL_AIW-1:0] tl_d_source_o,
  output logic [TL_DW-1:0]  tl_d_data_o,
  output logic              tl_d_error_o,
  input  logic              tl_d_ready_i
);

  // Checker to adapter
  logic tl_err;

  // Register interface
  logic              reg_re;
  logic              reg_we;
  logic [REG_AW-1:0] reg_addr;
  logic [REG_DW-1:0] reg_wdata;
  logic [REG_BW-1:0] reg_be;
  logic [REG_DW-1:0] reg_rdata;
  logic              reg_error;

  tlul_err u_err (
    .tl_a_valid_i   (tl_a_valid_i),
    .tl_a_opcode_i  (tl_a_opcode_i),
    .tl_a_size_i    (tl_a_size_i),
    .tl_a_mask_i    (tl_a_mask_i),
    .tl_a_address_i (tl_a_address_i),
    .tl_err_o       (tl_err)
  );

  tlul_adapter_reg u_adapter (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .tl_a_valid_i   (tl_a_valid_i),
    .tl_a_opcode_i  (tl_a_opcode_i),
    .tl_a_size_i    (tl_a_size_i),
    .tl_a_mask_i    (tl_a_mask_i),
    .tl_a_address_i (tl_a_address_i),
    .tl_a_source_i  (tl_a_source_i),
    .tl_a_data_i    (tl_a_data_i),
    .tl_a_ready_o   (tl_a_ready_o),
    .tl_d_valid_o   (tl_d_valid_o),
    .tl_d_opcode_o  (tl_d_opcode_o),
    .tl_d_size_o    (tl_d_size_o),
    .tl_d_source_o  (tl_d_source_o),
    .tl_d_data_o    (tl_d_data_o),
    .tl_d_error_o   (tl_d_error_o),
    .tl_d_ready_i   (tl_d_ready_i),
    .tl_err_i       (tl_err),
    .re_o           (reg_re),
    .we_o           (reg_we),
    .addr_o         (reg_addr),
    .wdata_o        (reg_wdata),
    .be_o           (reg_be),
    .rdata_i        (reg_rdata),
    .error_i        (reg_error)
  );

  reg_block u_regs (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .re_i    (reg_re),
    .we_i    (reg_we),
    .addr_i  (reg_addr),
    .wdata_i (reg_wdata),
    .be_i    (reg_be),
    .rdata_o (reg_rdata),
    .error_o (reg_error)
  );

endmodule

//--- tlul_reg_checker.sv
/*
  Monitor for the TL-UL register slave testbench.
  Predicts each response at the A handshake and compares it at the D handshake.
*/

`timescale 1ns/10ps

module tlul_reg_checker
  import tlul_pkg::*;
  import regs_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              tl_a_valid_i,
  input  logic              tl_a_ready_i,
  input  logic [2:0]        tl_a_opcode_i,
  input  logic [TL_SZW-1:0] tl_a_size_i,
  input  logic [TL_DBW-1:0] tl_a_mask_i,
  input  logic [TL_AW-1:0]  tl_a_address_i,
  input  logic [TL_AIW-1:0] tl_a_source_i,
  input  logic [TL_DW-1:0]  tl_a_data_i,
  input  logic              tl_d_valid_i,
  input  logic              tl_d_ready_i,
  input  logic [2:0]        tl_d_opcode_i,
  input  logic [TL_SZW-1:0] tl_d_size_i,
  input  logic [TL_AIW-1:0] tl_d_source_i,
  input  logic [TL_DW-1:0]  tl_d_data_i,
  input  logic              tl_d_error_i,
  output int                err_count_o,
  output int                pending_o
);

  typedef struct packed {
    logic [2:0]        op;
    logic [TL_SZW-1:0] size;
    logic [TL_AIW-1:0] source;
    logic [TL_DW-1:0]  data;
    logic              error;
  } rsp_t;

  // Responses still owed in arrival order
  rsp_t exp_q[$];
  int   errors = 0;
  int   pending = 0;

  // Register model
  logic [CTRL_W-1:0]   ctrl_m;
  logic [REG_DW-1:0]   scratch_m;
  logic [WCOUNT_W-1:0] wcount_m;

  assign err_count_o = errors;
  assign pending_o   = pending;

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  function automatic rsp_t predict(input logic [2:0] op, input logic [1:0] size,
                                   input logic [3:0] mask, input logic [31:0] addr,
                                   input logic [7:0] source, input logic [31:0] data);
    rsp_t       r;
    logic [3:0] lanes;
    logic       is_get;
    logic       is_put;
    logic       early;
    logic [7:0] word;
    is_get = (op == Get);
    is_put = (op == PutFullData) || (op == PutPartialData);
    // A lane is covered when it falls in the size-aligned block of the address
    for (int i = 0; i < 4; i++) begin
      lanes[i] = (size <= 2) && ((i >> size) == (int'(addr[1:0]) >> size));
    end
    early = !(is_get || is_put) || (size > 2) ||
            (int'(addr[1:0]) % (1 << size) != 0) ||
            ((mask & ~lanes) != 4'b0) ||
            ((op == PutFullData) && ((mask & lanes) != lanes));
    // Puts are word addressed
    early  = early || (is_put && addr[1:0] != 2'b00);
    r.op     = is_get ? AccessAckData : AccessAck;
    r.size   = size;
    r.source = source;
    r.data   = '0;
    r.error  = 1'b0;
    word = {addr[7:2], 2'b00};
    if (early) begin
      r.error = 1'b1;
      r.data  = '1;
    end else if (!(word inside {REG_CTRL, REG_SCRATCH, REG_ID, REG_WCOUNT})) begin
      r.error = 1'b1;
    end else if (is_get) begin
      case (word)
        REG_CTRL:    r.data = 32'(ctrl_m);
        REG_SCRATCH: r.data = scratch_m;
        REG_ID:      r.data = BLOCK_ID;
        default:     r.data = 32'(wcount_m);
      endcase
    end else if (word == REG_ID || word == REG_WCOUNT) begin
      r.error = 1'b1;
    end else begin
      if (word == REG_CTRL && mask[0]) begin
        ctrl_m = data[7:0];
      end
      if (word == REG_SCRATCH) begin
        for (int b = 0; b < 4; b++) begin
          if (mask[b]) scratch_m[b*8 +: 8] = data[b*8 +: 8];
        end
      end
      wcount_m = wcount_m + 1'b1;
    end
    return r;
  endfunction

  task automatic check_field(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    if (exp_v !== act_v) begin
      errors++;
      $display("Error at time %0t: %s expected %h, actual %h", $time, name, exp_v, act_v);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Compare process
  ////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    rsp_t expected;
    logic busy;
    if (!rst_ni) begin
      ctrl_m    = CTRL_RESET;
      scratch_m = SCRATCH_RESET;
      wcount_m  = '0;
      exp_q.delete();
    end else begin
      // Owed from the edge after acceptance until the D handshake
      busy = (exp_q.size() != 0);
      check_field("tl_d_valid_o", 32'(busy), 32'(tl_d_valid_i));
      // Requests wait on the A channel while a response is owed
      if (busy) begin
        check_field("tl_a_ready_o", 32'(1'b0), 32'(tl_a_ready_i));
      end
      if (tl_d_valid_i && tl_d_ready_i) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("Error at time %0t: a D response arrived with no request outstanding", $time);
        end else begin
          expected = exp_q.pop_front();
          check_field("tl_d_opcode_o", 32'(expected.op), 32'(tl_d_opcode_i));
          check_field("tl_d_size_o", 32'(expected.size), 32'(tl_d_size_i));
          check_field("tl_d_source_o", 32'(expected.source), 32'(tl_d_source_i));
          check_field("tl_d_error_o", 32'(expected.error), 32'(tl_d_error_i));
          // Data only carries meaning on AccessAckData
          if (expected.op == AccessAckData) begin
            check_field("tl_d_data_o", expected.data, tl_d_data_i);
          end
        end
      end
      if (tl_a_valid_i && tl_a_ready_i) begin
        exp_q.push_back(predict(tl_a_opcode_i, tl_a_size_i, tl_a_mask_i, tl_a_address_i,
                                tl_a_source_i, tl_a_data_i));
      end
    end
    pending = exp_q.size();
  end

endmodule

//--- tb_tlul_reg_top.sv
/*
  Testbench for the TL-UL register slave.
  Drives requests on the falling edge; tlul_reg_checker predicts and compares the responses.
*/

`timescale 1ns/10ps

module tb_tlul_reg_top
  import tlul_pkg::*;
  import regs_pkg::*;
();

  localparam logic [31:0] SEED    = 32'h1cf9_5b05;
  localparam int          NUM_RND = 40;
  localparam int          TIMEOUT = 100;

  logic              clk_i;
  logic              rst_ni;
  logic              tl_a_valid_i;
  tl_a_op_e          tl_a_opcode_i;
  logic [TL_SZW-1:0] tl_a_size_i;
  logic [TL_DBW-1:0] tl_a_mask_i;
  logic [TL_AW-1:0]  tl_a_address_i;
  logic [TL_AIW-1:0] tl_a_source_i;
  logic [TL_DW-1:0]  tl_a_data_i;
  logic              tl_a_ready_o;
  logic              tl_d_valid_o;
  tl_d_op_e          tl_d_opcode_o;
  logic [TL_SZW-1:0] tl_d_size_o;
  logic [TL_AIW-1:0] tl_d_source_o;
  logic [TL_DW-1:0]  tl_d_data_o;
  logic              tl_d_error_o;
  logic              tl_d_ready_i = 1'b0;

  // Back-pressure state
  logic d_fire = 1'b0;
  int   hold = 0;

  int   tb_errors;
  logic aborted;
  int   chk_errors;
  int   chk_pending;

  tlul_reg_top tlul_reg_top_inst (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .tl_a_valid_i   (tl_a_valid_i),
    .tl_a_opcode_i  (tl_a_opcode_i),
    .tl_a_size_i    (tl_a_size_i),
    .tl_a_mask_i    (tl_a_mask_i),
    .tl_a_address_i (tl_a_address_i),
    .tl_a_source_i  (tl_a_source_i),
    .tl_a_data_i    (tl_a_data_i),
    .tl_a_ready_o   (tl_a_ready_o),
    .tl_d_valid_o   (tl_d_valid_o),
    .tl_d_opcode_o  (tl_d_opcode_o),
    .tl_d_size_o    (tl_d_size_o),
    .tl_d_source_o  (tl_d_source_o),
    .tl_d_data_o    (tl_d_data_o),
    .tl_d_error_o   (tl_d_error_o),
    .tl_d_ready_i   (tl_d_ready_i)
  );

  tlul_reg_checker u_checker (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .tl_a_valid_i   (tl_a_valid_i),
    .tl_a_ready_i   (tl_a_ready_o),
    .tl_a_opcode_i  (tl_a_opcode_i),
    .tl_a_size_i    (tl_a_size_i),
    .tl_a_mask_i    (tl_a_mask_i),
    .tl_a_address_i (tl_a_address_i),
    .tl_a_source_i  (tl_a_source_i),
    .tl_a_data_i    (tl_a_data_i),
    .tl_d_valid_i   (tl_d_valid_o),
    .tl_d_ready_i   (tl_d_ready_i),
    .tl_d_opcode_i  (tl_d_opcode_o),
    .tl_d_size_i    (tl_d_size_o),
    .tl_d_source_i  (tl_d_source_o),
    .tl_d_data_i    (tl_d_data_o),
    .tl_d_error_i   (tl_d_error_o),
    .err_count_o    (chk_errors),
    .pending_o      (chk_pending)
  );

  // 8 ns clock
  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////
  // D channel back-pressure
  ////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    d_fire <= tl_d_valid_o & tl_d_ready_i;
  end

  // After each response, ready drops for 0 to 3 cycles
  always @(negedge clk_i) begin
    if (d_fire) begin
      hold = $urandom_range(3, 0);
    end
    if (hold > 0) begin
      tl_d_ready_i = 1'b0;
      hold--;
    end else begin
      tl_d_ready_i = 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  // Lanes of a transfer that starts at lane 0
  function automatic logic [3:0] low_lanes(input logic [1:0] size);
    return (size == 2'd0) ? 4'b0001 : (size == 2'd1) ? 4'b0011 : 4'b1111;
  endfunction

  // Called on a falling edge; returns on the falling edge after acceptance
  task automatic send_request(input logic [2:0] op, input logic [1:0] size,
                              input logic [3:0] mask, input logic [31:0] addr,
                              input logic [31:0] data);
    int waited;
    if (aborted) return;
    tl_a_valid_i   = 1'b1;
    tl_a_opcode_i  = tl_a_op_e'(op);
    tl_a_size_i    = size;
    tl_a_mask_i    = mask;
    tl_a_address_i = addr;
    tl_a_source_i  = TL_AIW'($urandom);
    tl_a_data_i    = data;
    waited = 0;
    // Ready only changes on the rising edge
    while (!tl_a_ready_o) begin
      @(negedge clk_i);
      waited++;
      if (waited > TIMEOUT) begin
        $display("Timeout at time %0t: tl_a_ready_o stayed low for %0d cycles", $time, TIMEOUT);
        tb_errors++;
        aborted = 1'b1;
        tl_a_valid_i = 1'b0;
        return;
      end
    end
    @(negedge clk_i);
    tl_a_valid_i = 1'b0;
  endtask

  task automatic drain_responses();
    int waited;
    waited = 0;
    while (tl_d_valid_o || chk_pending != 0) begin
      @(negedge clk_i);
      waited++;
      if (waited > TIMEOUT) begin
        $display("Timeout at time %0t: responses still outstanding at the end", $time);
        tb_errors++;
        return;
      end
    end
  endtask

  task automatic finish_run();
    $display("Checker errors: %0d, driver errors: %0d", chk_errors, tb_errors);
    if (chk_errors + tb_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] addr_r;
    logic [1:0]  size_r;
    logic [3:0]  mask_r;
    logic [2:0]  op_r;
    int          kind;
    void'($urandom(SEED));
    tb_errors      = 0;
    aborted        = 1'b0;
    rst_ni         = 1'b0;
    tl_a_valid_i   = 1'b0;
    tl_a_opcode_i  = Get;
    tl_a_size_i    = '0;
    tl_a_mask_i    = '0;
    tl_a_address_i = '0;
    tl_a_source_i  = '0;
    tl_a_data_i    = '0;
    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);

    // Reset values of all four words
    for (int i = 0; i < 4; i++) begin
      send_request(Get, 2'd2, 4'hf, 32'(i * 4), '0);
    end

    // Byte-merged writes to control and scratch, read back now and then
    for (int n = 0; n < NUM_RND; n++) begin
      addr_r = $urandom_range(1, 0) ? REG_SCRATCH : REG_CTRL;
      size_r = $urandom_range(2, 0);
      mask_r = low_lanes(size_r);
      op_r   = $urandom_range(1, 0) ? PutFullData : PutPartialData;
      if (op_r == PutPartialData) begin
        mask_r = mask_r & 4'($urandom);
      end
      send_request(op_r, size_r, mask_r, addr_r, $urandom);
      if (n % 4 == 3) begin
        send_request(Get, 2'd2, 4'hf, REG_CTRL, '0);
        send_request(Get, 2'd2, 4'hf, REG_SCRATCH, '0);
      end
    end

    // Mix of legal, illegal and read-only writes for the counter
    for (int n = 0; n < NUM_RND; n++) begin
      kind = $urandom_range(3, 0);
      case (kind)
        0: send_request(PutFullData, 2'd2, 4'hf,
                        $urandom_range(1, 0) ? REG_SCRATCH : REG_CTRL, $urandom);
        1: send_request(PutPartialData, 2'd0, 4'b0110, REG_SCRATCH, $urandom);
        2: send_request(PutFullData, 2'd2, 4'hf,
                        $urandom_range(1, 0) ? REG_ID : REG_WCOUNT, $urandom);
        default: send_request(PutPartialData, 2'd0, 4'b0010, REG_SCRATCH + 1, $urandom);
      endcase
    end
    send_request(Get, 2'd2, 4'hf, REG_WCOUNT, '0);

    // Error cases, each followed by a read of the target
    send_request(Get, 2'd2, 4'hf, 32'h10, '0);
    send_request(PutFullData, 2'd2, 4'hf, 32'h40, $urandom);
    send_request(PutFullData, 2'd2, 4'hf, REG_ID, 32'hdead_beef);
    send_request(Get, 2'd2, 4'hf, REG_ID, '0);
    send_request(PutFullData, 2'd3, 4'hf, REG_SCRATCH, $urandom);
    send_request(Get, 2'd2, 4'hf, REG_SCRATCH, '0);
    send_request(PutPartialData, 2'd1, 4'b1100, REG_SCRATCH + 2, $urandom);
    send_request(Get, 2'd2, 4'hf, REG_SCRATCH, '0);
    send_request(PutPartialData, 2'd0, 4'b0011, REG_CTRL, $urandom);
    send_request(3'h2, 2'd2, 4'hf, REG_CTRL, $urandom);
    send_request(3'h7, 2'd2, 4'hf, REG_CTRL, $urandom);
    send_request(Get, 2'd2, 4'hf, REG_CTRL, '0);
    // Checker errors on a Get give all ones
    send_request(Get, 2'd3, 4'hf, REG_ID, '0);
    send_request(Get, 2'd2, 4'hf, REG_ID + 1, '0);
    send_request(Get, 2'd2, 4'hf, REG_WCOUNT, '0);

    // Random sizes and sources under back-pressure
    for (int n = 0; n < NUM_RND; n++) begin
      size_r = $urandom_range(2, 0);
      addr_r = 32'(4 * $urandom_range(3, 0));
      send_request(Get, size_r, low_lanes(size_r), addr_r, '0);
    end

    drain_responses();
    finish_run();
  end

endmodule

//--- filelist.f
tlul_pkg.sv
regs_pkg.sv
tlul_err.sv
tlul_adapter_reg.sv
reg_block.sv
tlul_reg_top.sv
tlul_reg_checker.sv
tb_tlul_reg_top.sv
